/* rtl/smem_settings.svh */
`ifndef SMEM_SETTINGS_SVH
`define SMEM_SETTINGS_SVH

// ------------------------------
// widths
// ------------------------------
`define SMEM_CL          512 // load word and output line
`define SMEM_READ_NUM_W  10  // batch size is one bit wider
`define SMEM_MAX_BASES   101
`define SMEM_POS_W       7   // base position or length
`define SMEM_IDX_W       32  // index position, count, address

`define SMEM_FIFO_DEPTH  4

// ------------------------------
// field positions in load words and output lines
// ------------------------------
`define SMEM_NUM_LSB     0
`define SMEM_LEN_LSB     10
`define SMEM_BASE_LSB    32  // read words only, base 0 first
`define SMEM_K_LSB       32  // output lines only
`define SMEM_L_LSB       64

`endif

/* rtl/smem_pkg.sv */
`default_nettype none

`include "smem_settings.svh"

package smem_pkg;

	// 0..3 stand for A, C, G, T
	typedef logic [1:0] smem_base_t;

	// one read as it sits in the read FIFO
	typedef struct packed {
		logic [`SMEM_READ_NUM_W-1:0] num;
		logic [`SMEM_POS_W-1:0] len;
		smem_base_t [`SMEM_MAX_BASES-1:0] bases; // base 0 in the low bits
	} smem_read_t;

	// half-open suffix interval, empty when l <= k
	typedef struct packed {
		logic [`SMEM_IDX_W-1:0] k;
		logic [`SMEM_IDX_W-1:0] l;
	} smem_intv_t;

	typedef struct packed {
		logic [`SMEM_READ_NUM_W-1:0] num;
		logic [`SMEM_POS_W-1:0] len; // bases matched
		smem_intv_t intv;
	} smem_result_t;

	// same bit order as the parameter word, l2[0] at bit 0
	typedef struct packed {
		logic [`SMEM_IDX_W-1:0] seq_len;
		logic [3:0][`SMEM_IDX_W-1:0] l2;
	} smem_params_t;

endpackage

`default_nettype wire

/* rtl/smem_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module smem_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int DEPTH = 4
) (
	input  logic     Clk_32UI,
	input  logic     rst_n_i,
	input  logic     push_i,
	input  payload_t data_i,
	output logic     full_o,
	input  logic     pop_i,
	output payload_t data_o,
	output logic     empty_o
);
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	payload_t mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr_q;
	logic [PTR_W-1:0] rd_ptr_q;
	logic [CNT_W-1:0] count_q;

	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign full_o  = (count_q == CNT_W'(DEPTH));
	assign empty_o = (count_q == '0);
	assign data_o  = mem[rd_ptr_q]; // head is visible before the pop

	always_ff @(posedge Clk_32UI) begin
		if (push_i) begin
			mem[wr_ptr_q] <= data_i;
		end
	end

	always_ff @(posedge Clk_32UI or negedge rst_n_i) begin
		if (!rst_n_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end else begin
			if (push_i)
				wr_ptr_q <= ptr_inc(wr_ptr_q);
			if (pop_i)
				rd_ptr_q <= ptr_inc(rd_ptr_q);
			case ({push_i, pop_i})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: count_q <= count_q;
			endcase
		end
	end

	// both neighbours must respect the flags
	assert property (@(posedge Clk_32UI) disable iff (!rst_n_i)
		!(push_i && full_o) && !(pop_i && empty_o))
		else $error("smem_fifo: push when full or pop when empty");

endmodule

`default_nettype wire

/* rtl/read_loader.sv */
`timescale 1ns/1ps
`default_nettype none

`include "smem_settings.svh"

module read_loader (
	input  logic                       Clk_32UI,
	input  logic                       rst_n_i,
	input  logic                       load_valid_i,
	input  logic [`SMEM_CL-1:0]        load_data_i,
	input  logic [`SMEM_READ_NUM_W:0]  batch_size_i,
	input  logic                       fifo_full_i,
	output logic                       load_ready_o,
	output logic                       load_done_o,
	output smem_pkg::smem_params_t     params_o,
	output logic                       read_push_o,
	output smem_pkg::smem_read_t       read_o
);
	logic have_params_q; // word 0 already taken
	logic [`SMEM_READ_NUM_W:0] read_cnt_q;
	logic [`SMEM_READ_NUM_W:0] read_cnt_nxt;
	logic take;

	// a read still waiting in read_o counts as a FIFO slot
	assign load_ready_o = !load_done_o && !fifo_full_i && !read_push_o;
	assign take         = load_valid_i && load_ready_o;
	assign read_cnt_nxt = read_cnt_q + 1'b1;

	// ------------------------------
	// word count and done flag
	// ------------------------------
	always_ff @(posedge Clk_32UI or negedge rst_n_i) begin
		if (!rst_n_i) begin
			have_params_q <= 1'b0;
			read_cnt_q    <= '0;
			read_push_o   <= 1'b0;
			load_done_o   <= 1'b0;
		end else begin
			read_push_o <= take && have_params_q; // push one cycle after the take
			if (take) begin
				if (!have_params_q) begin
					have_params_q <= 1'b1;
					load_done_o   <= (batch_size_i == '0); // empty batch
				end else begin
					read_cnt_q  <= read_cnt_nxt;
					load_done_o <= (read_cnt_nxt == batch_size_i);
				end
			end
		end
	end

	// ------------------------------
	// unpacking
	// ------------------------------
	always_ff @(posedge Clk_32UI) begin
		if (take && !have_params_q) begin
			params_o <= load_data_i[$bits(smem_pkg::smem_params_t)-1:0];
		end
		if (take && have_params_q) begin
			read_o.num   <= load_data_i[`SMEM_NUM_LSB +: `SMEM_READ_NUM_W];
			read_o.len   <= load_data_i[`SMEM_LEN_LSB +: `SMEM_POS_W];
			read_o.bases <= load_data_i[`SMEM_BASE_LSB +: 2*`SMEM_MAX_BASES];
		end
	end

	// the push that follows a read word never lands on a full FIFO
	assert property (@(posedge Clk_32UI) disable iff (!rst_n_i)
		take && have_params_q |=> !fifo_full_i)
		else $error("read_loader: read word taken without room in the read FIFO");

endmodule

`default_nettype wire

/* rtl/fm_extend.sv */
`timescale 1ns/1ps
`default_nettype none

`include "smem_settings.svh"

module fm_extend (
	input  logic                          Clk_32UI,
	input  logic                          rst_n_i,
	input  smem_pkg::smem_params_t        params_i,
	input  logic                          read_empty_i,
	input  smem_pkg::smem_read_t          read_i,
	input  logic                          result_full_i,
	input  logic                          mem_ack_i,
	input  logic [`SMEM_IDX_W-1:0]        occ_k_i,
	input  logic [`SMEM_IDX_W-1:0]        occ_l_i,
	output logic                          read_pop_o,
	output logic                          mem_req_o,
	output smem_pkg::smem_base_t          mem_base_o,
	output logic [`SMEM_IDX_W-1:0]        mem_addr_k_o,
	output logic [`SMEM_IDX_W-1:0]        mem_addr_l_o,
	output logic [`SMEM_READ_NUM_W-1:0]   mem_read_num_o,
	output logic                          result_push_o,
	output smem_pkg::smem_result_t        result_o
);
	typedef enum logic [2:0] {
		S_IDLE,
		S_REQ,       // req high, waiting for ack
		S_WAIT_DROP, // req low, waiting for ack to fall
		S_UPDATE,
		S_PUSH
	} state_t;

	state_t state_q;
	smem_pkg::smem_read_t read_q;
	smem_pkg::smem_intv_t intv_q;
	smem_pkg::smem_intv_t intv_nxt;
	smem_pkg::smem_base_t base_c;
	logic [`SMEM_POS_W-1:0] pos_q;
	logic [`SMEM_POS_W-1:0] mlen_q;
	logic [`SMEM_IDX_W-1:0] occ_k_q;
	logic [`SMEM_IDX_W-1:0] occ_l_q;
	logic [`SMEM_IDX_W-1:0] l2_c;
	logic intv_empty;
	logic last_base;

	// ------------------------------
	// interval update for the current base
	// ------------------------------
	assign base_c     = read_q.bases[pos_q];
	assign l2_c       = params_i.l2[base_c];
	assign intv_nxt   = '{k: l2_c + occ_k_q, l: l2_c + occ_l_q};
	assign intv_empty = (intv_nxt.l <= intv_nxt.k);
	assign last_base  = (pos_q == read_q.len - 1'b1);

	assign read_pop_o     = (state_q == S_IDLE) && !read_empty_i;
	assign mem_req_o      = (state_q == S_REQ);
	assign mem_base_o     = base_c;
	assign mem_addr_k_o   = intv_q.k;
	assign mem_addr_l_o   = intv_q.l;
	assign mem_read_num_o = read_q.num;
	assign result_push_o  = (state_q == S_PUSH) && !result_full_i;
	assign result_o       = '{num: read_q.num, len: mlen_q, intv: intv_q};

	always_ff @(posedge Clk_32UI or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q <= S_IDLE;
		end else begin
			case (state_q)
				S_IDLE: begin
					if (!read_empty_i)
						state_q <= (read_i.len == '0) ? S_PUSH : S_REQ; // zero length skips memory
				end
				S_REQ: begin
					if (mem_ack_i)
						state_q <= S_WAIT_DROP;
				end
				S_WAIT_DROP: begin
					if (!mem_ack_i)
						state_q <= S_UPDATE;
				end
				S_UPDATE: state_q <= (intv_empty || last_base) ? S_PUSH : S_REQ;
				S_PUSH: begin
					if (!result_full_i)
						state_q <= S_IDLE;
				end
				default: state_q <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge Clk_32UI) begin
		case (state_q)
			S_IDLE: begin
				if (!read_empty_i) begin
					read_q <= read_i;
					intv_q <= '{k: '0, l: params_i.seq_len}; // whole index
					pos_q  <= '0;
					mlen_q <= '0;
				end
			end
			S_REQ: begin
				if (mem_ack_i) begin
					occ_k_q <= occ_k_i;
					occ_l_q <= occ_l_i;
				end
			end
			S_UPDATE: begin
				if (!intv_empty) begin
					intv_q <= intv_nxt; // keep the last non-empty one
					mlen_q <= mlen_q + 1'b1;
				end
				pos_q <= pos_q + 1'b1;
			end
			default: ;
		endcase
	end

	// request lines hold until the responder acks
	assert property (@(posedge Clk_32UI) disable iff (!rst_n_i)
		mem_req_o && !mem_ack_i |=>
			$stable({mem_base_o, mem_addr_k_o, mem_addr_l_o, mem_read_num_o}))
		else $error("fm_extend: request changed before ack");

	assert property (@(posedge Clk_32UI) disable iff (!rst_n_i)
		$rose(mem_req_o) |-> !mem_ack_i)
		else $error("fm_extend: new request while ack still high");

endmodule

`default_nettype wire

/* rtl/result_writer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "smem_settings.svh"

module result_writer (
	input  logic                       Clk_32UI,
	input  logic                       rst_n_i,
	input  logic [`SMEM_READ_NUM_W:0]  batch_size_i,
	input  logic                       result_empty_i,
	input  smem_pkg::smem_result_t     result_i,
	input  logic                       output_permit_i,
	output logic                       result_pop_o,
	output logic                       output_request_o,
	output logic [`SMEM_CL-1:0]        output_data_o,
	output logic                       output_valid_o,
	output logic                       output_finish_o
);
	logic burst_q; // draining the FIFO after a permit
	logic [`SMEM_READ_NUM_W:0] sent_q;
	logic [`SMEM_READ_NUM_W:0] sent_nxt;
	logic [`SMEM_CL-1:0] line;

	assign output_request_o = !result_empty_i && !burst_q;
	assign result_pop_o     = burst_q && !result_empty_i;
	assign sent_nxt         = sent_q + 1'b1;

	// line layout with zeros outside the fields
	always_comb begin
		line = '0;
		line[`SMEM_NUM_LSB +: `SMEM_READ_NUM_W] = result_i.num;
		line[`SMEM_LEN_LSB +: `SMEM_POS_W]      = result_i.len;
		line[`SMEM_K_LSB +: `SMEM_IDX_W]        = result_i.intv.k;
		line[`SMEM_L_LSB +: `SMEM_IDX_W]        = result_i.intv.l;
	end

	// ------------------------------
	// burst control
	// ------------------------------
	always_ff @(posedge Clk_32UI or negedge rst_n_i) begin
		if (!rst_n_i) begin
			burst_q         <= 1'b0;
			sent_q          <= '0;
			output_valid_o  <= 1'b0;
			output_finish_o <= 1'b0;
		end else begin
			output_valid_o  <= result_pop_o;
			output_finish_o <= result_pop_o && (sent_nxt == batch_size_i); // last of the batch
			if (result_pop_o)
				sent_q <= sent_nxt;
			if (output_request_o && output_permit_i)
				burst_q <= 1'b1;
			else if (burst_q && result_empty_i)
				burst_q <= 1'b0; // drained
		end
	end

	always_ff @(posedge Clk_32UI) begin
		if (result_pop_o)
			output_data_o <= line;
	end

	// lines only come from a permitted burst
	assert property (@(posedge Clk_32UI) disable iff (!rst_n_i)
		output_valid_o |-> $past(burst_q))
		else $error("result_writer: line outside a permitted burst");

endmodule

`default_nettype wire

/* rtl/smem_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "smem_settings.svh"

module smem_top (
	input  logic                          Clk_32UI,
	input  logic                          rst_n_i,
	// load port
	input  logic                          load_valid_i,
	input  logic [`SMEM_CL-1:0]           load_data_i,
	input  logic [`SMEM_READ_NUM_W:0]     batch_size_i,
	output logic                          load_ready_o,
	output logic                          load_done_o,
	// memory port
	output logic                          mem_req_o,
	output smem_pkg::smem_base_t          mem_base_o,
	output logic [`SMEM_IDX_W-1:0]        mem_addr_k_o,
	output logic [`SMEM_IDX_W-1:0]        mem_addr_l_o,
	output logic [`SMEM_READ_NUM_W-1:0]   mem_read_num_o,
	input  logic                          mem_ack_i,
	input  logic [`SMEM_IDX_W-1:0]        occ_k_i,
	input  logic [`SMEM_IDX_W-1:0]        occ_l_i,
	// output port
	output logic                          output_request_o,
	input  logic                          output_permit_i,
	output logic [`SMEM_CL-1:0]           output_data_o,
	output logic                          output_valid_o,
	output logic                          output_finish_o
);
	smem_pkg::smem_params_t params;
	smem_pkg::smem_read_t read_in, read_head;
	smem_pkg::smem_result_t result_in, result_head;
	logic read_push, read_full, read_pop, read_empty;
	logic result_push, result_full, result_pop, result_empty;

	read_loader u_loader (
		.Clk_32UI(Clk_32UI), .rst_n_i(rst_n_i),
		.load_valid_i(load_valid_i), .load_data_i(load_data_i),
		.batch_size_i(batch_size_i), .fifo_full_i(read_full),
		.load_ready_o(load_ready_o), .load_done_o(load_done_o),
		.params_o(params), .read_push_o(read_push), .read_o(read_in)
	);

	smem_fifo #(.payload_t(smem_pkg::smem_read_t), .DEPTH(`SMEM_FIFO_DEPTH)) u_read_fifo (
		.Clk_32UI(Clk_32UI), .rst_n_i(rst_n_i),
		.push_i(read_push), .data_i(read_in), .full_o(read_full),
		.pop_i(read_pop), .data_o(read_head), .empty_o(read_empty)
	);

	fm_extend u_extend (
		.Clk_32UI(Clk_32UI), .rst_n_i(rst_n_i), .params_i(params),
		.read_empty_i(read_empty), .read_i(read_head), .result_full_i(result_full),
		.mem_ack_i(mem_ack_i), .occ_k_i(occ_k_i), .occ_l_i(occ_l_i),
		.read_pop_o(read_pop), .mem_req_o(mem_req_o), .mem_base_o(mem_base_o),
		.mem_addr_k_o(mem_addr_k_o), .mem_addr_l_o(mem_addr_l_o),
		.mem_read_num_o(mem_read_num_o),
		.result_push_o(result_push), .result_o(result_in)
	);

	smem_fifo #(.payload_t(smem_pkg::smem_result_t), .DEPTH(`SMEM_FIFO_DEPTH)) u_result_fifo (
		.Clk_32UI(Clk_32UI), .rst_n_i(rst_n_i),
		.push_i(result_push), .data_i(result_in), .full_o(result_full),
		.pop_i(result_pop), .data_o(result_head), .empty_o(result_empty)
	);

	result_writer u_writer (
		.Clk_32UI(Clk_32UI), .rst_n_i(rst_n_i), .batch_size_i(batch_size_i),
		.result_empty_i(result_empty), .result_i(result_head),
		.output_permit_i(output_permit_i), .result_pop_o(result_pop),
		.output_request_o(output_request_o), .output_data_o(output_data_o),
		.output_valid_o(output_valid_o), .output_finish_o(output_finish_o)
	);

endmodule

`default_nettype wire

/* bench/smem_tb_vectors.svh */
`ifndef SMEM_TB_VECTORS_SVH
`define SMEM_TB_VECTORS_SVH

localparam int NUM_READS = 10; // more than both FIFOs hold
localparam logic [`SMEM_IDX_W-1:0] SEQ_LEN = 32'h0100_0000;

// ------------------------------
// read table, in load order
// ------------------------------
function automatic string read_seq(input int idx);
	case (idx)
		0: return "ACGT"; // matches every base
		1: return "TTTTTTTTTTTT"; // empties early
		2: return "G"; // single base
		3: return "CAGTTACG";
		4: return "AAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAA";
		5: return "GATTACA";
		6: return "CCCC";
		7: return "TGCA";
		8: return "ACGTACGTACGT";
		default: return "T";
	endcase
endfunction

function automatic logic [`SMEM_READ_NUM_W-1:0] read_num(input int idx);
	return `SMEM_READ_NUM_W'(3 * idx + 512);
endfunction

function automatic smem_pkg::smem_base_t base_code(input byte ch);
	case (ch)
		"A": return 2'd0;
		"C": return 2'd1;
		"G": return 2'd2;
		default: return 2'd3;
	endcase
endfunction

function automatic int total_bases();
	int n = 0;
	for (int i = 0; i < NUM_READS; i++)
		n += read_seq(i).len();
	return n;
endfunction

// ------------------------------
// reference model
// ------------------------------
function automatic logic [`SMEM_IDX_W-1:0] l2_of(input smem_pkg::smem_base_t c);
	return 32'h0000_0001 + {c, 22'h0}; // quarter of the index per base
endfunction

// occ(pos, c) of the test index
function automatic logic [`SMEM_IDX_W-1:0] occ_of(input logic [`SMEM_IDX_W-1:0] pos,
		input smem_pkg::smem_base_t c);
	return pos >> (32'(c) + 1);
endfunction

// queues the requests and the result of one read
task automatic model_read(input int idx);
	string seq;
	smem_pkg::smem_result_t res;
	smem_pkg::smem_intv_t nxt;
	req_rec_t req;
	seq = read_seq(idx);
	res = '{num: read_num(idx), len: '0, intv: '{k: '0, l: SEQ_LEN}};
	for (int i = 0; i < seq.len(); i++) begin
		req.num = res.num;
		req.base = base_code(seq[i]);
		req.intv = res.intv; // interval before this base
		exp_req.push_back(req);
		nxt.k = l2_of(req.base) + occ_of(res.intv.k, req.base);
		nxt.l = l2_of(req.base) + occ_of(res.intv.l, req.base);
		if (nxt.l <= nxt.k)
			break;
		res.intv = nxt;
		res.len = res.len + 1'b1;
	end
	exp_res.push_back(res);
endtask

`endif

/* bench/smem_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "smem_settings.svh"

module smem_tb;
	typedef struct packed {
		logic [`SMEM_READ_NUM_W-1:0] num;
		smem_pkg::smem_base_t base;
		smem_pkg::smem_intv_t intv;
	} req_rec_t;

	logic Clk_32UI;
	logic rst_n_i;
	logic load_valid_i;
	logic [`SMEM_CL-1:0] load_data_i;
	logic [`SMEM_READ_NUM_W:0] batch_size_i;
	logic load_ready_o;
	logic load_done_o;
	logic mem_req_o;
	smem_pkg::smem_base_t mem_base_o;
	logic [`SMEM_IDX_W-1:0] mem_addr_k_o;
	logic [`SMEM_IDX_W-1:0] mem_addr_l_o;
	logic [`SMEM_READ_NUM_W-1:0] mem_read_num_o;
	logic mem_ack_i;
	logic [`SMEM_IDX_W-1:0] occ_k_i;
	logic [`SMEM_IDX_W-1:0] occ_l_i;
	logic output_request_o;
	logic output_permit_i;
	logic [`SMEM_CL-1:0] output_data_o;
	logic output_valid_o;
	logic output_finish_o;

	req_rec_t exp_req [$];
	smem_pkg::smem_result_t exp_res [$];
	logic [31:0] lfsr_q;
	int errors = 0;
	int checks = 0;
	int lines_seen = 0;
	int reads_taken = 0;
	logic params_taken = 1'b0;
	logic permitted = 1'b0; // last request was answered by a permit

	`include "smem_tb_vectors.svh"

	smem_top dut_i (.*);

	initial Clk_32UI = 1'b0;
	always #20 Clk_32UI = ~Clk_32UI; // 40 ns period

	// taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic draw_bits(input int n, output int val);
		val = 0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = lfsr_next(lfsr_q); // one step per bit
			val = (val << 1) | int'(lfsr_q[0]);
		end
	endtask

	task automatic check_eq(input string name, input logic [63:0] want, input logic [63:0] got);
		checks++;
		assert (want === got) else begin
			errors++;
			$display("[FAIL] %s: expected %0h, actual %0h", name, want, got);
		end
	endtask

	task automatic check_true(input logic cond, input string what);
		checks++;
		assert (cond) else begin
			errors++;
			$display("error: %s", what);
		end
	endtask

	function automatic logic [`SMEM_CL-1:0] param_word();
		logic [`SMEM_CL-1:0] w;
		w = '0;
		for (int c = 0; c < 4; c++)
			w[32*c +: 32] = l2_of(2'(c));
		w[128 +: 32] = SEQ_LEN;
		return w;
	endfunction

	function automatic logic [`SMEM_CL-1:0] read_word(input int idx);
		string seq;
		logic [`SMEM_CL-1:0] w;
		seq = read_seq(idx);
		w = '0;
		w[`SMEM_NUM_LSB +: `SMEM_READ_NUM_W] = read_num(idx);
		w[`SMEM_LEN_LSB +: `SMEM_POS_W] = `SMEM_POS_W'(seq.len());
		for (int i = 0; i < seq.len(); i++)
			w[`SMEM_BASE_LSB + 2*i +: 2] = base_code(seq[i]);
		return w;
	endfunction

	// hold the word until it is taken
	task automatic send_word(input logic [`SMEM_CL-1:0] w);
		load_valid_i <= 1'b1;
		load_data_i <= w;
		@(posedge Clk_32UI);
		while (!load_ready_o)
			@(posedge Clk_32UI);
	endtask

	// ------------------------------
	// memory responder and permit source
	// ------------------------------
	initial begin : mem_responder
		req_rec_t want;
		int delay;
		forever begin
			@(posedge Clk_32UI);
			if (rst_n_i && mem_req_o && !mem_ack_i) begin
				if (exp_req.size() == 0) begin
					check_true(1'b0, "memory request after the last expected base");
				end else begin
					want = exp_req.pop_front();
					check_eq($sformatf("read %0d req num", want.num), 64'(want.num), 64'(mem_read_num_o));
					check_eq($sformatf("read %0d req base", want.num), 64'(want.base), 64'(mem_base_o));
					check_eq($sformatf("read %0d req k", want.num), 64'(want.intv.k), 64'(mem_addr_k_o));
					check_eq($sformatf("read %0d req l", want.num), 64'(want.intv.l), 64'(mem_addr_l_o));
				end
				draw_bits(4, delay);
				repeat (delay) @(posedge Clk_32UI);
				mem_ack_i <= 1'b1;
				occ_k_i <= occ_of(mem_addr_k_o, mem_base_o);
				occ_l_i <= occ_of(mem_addr_l_o, mem_base_o);
				@(posedge Clk_32UI);
				while (mem_req_o)
					@(posedge Clk_32UI);
				mem_ack_i <= 1'b0; // four-phase release
			end
		end
	end

	initial begin : permit_source
		int delay;
		forever begin
			@(posedge Clk_32UI);
			if (rst_n_i && output_request_o && !output_permit_i) begin
				draw_bits(5, delay);
				repeat (delay) @(posedge Clk_32UI);
				output_permit_i <= 1'b1;
				@(posedge Clk_32UI);
				while (output_request_o)
					@(posedge Clk_32UI);
				output_permit_i <= 1'b0;
			end
		end
	end

	// ------------------------------
	// load and output monitor
	// ------------------------------
	always @(posedge Clk_32UI) begin
		smem_pkg::smem_result_t want;
		string name;
		if (rst_n_i) begin
			check_true(!load_done_o || reads_taken == NUM_READS, "load_done_o rose before the whole batch");
			if (load_valid_i && load_ready_o) begin
				if (params_taken)
					reads_taken++;
				params_taken = 1'b1;
			end
			check_true(!output_valid_o || permitted, "result line sent without a permit");
			check_true(!output_finish_o || output_valid_o, "output_finish_o high without a line");
			if (output_request_o)
				permitted = output_permit_i;
			if (output_valid_o && exp_res.size() == 0) begin
				check_true(1'b0, "extra result line after the last read");
			end else if (output_valid_o) begin
				want = exp_res.pop_front(); // load order
				name = $sformatf("line %0d", lines_seen);
				check_eq({name, " num"}, 64'(want.num), 64'(output_data_o[9:0]));
				check_eq({name, " len"}, 64'(want.len), 64'(output_data_o[16:10]));
				check_eq({name, " k"}, 64'(want.intv.k), 64'(output_data_o[63:32]));
				check_eq({name, " l"}, 64'(want.intv.l), 64'(output_data_o[95:64]));
				check_eq({name, " finish"}, 64'(lines_seen == NUM_READS - 1), 64'(output_finish_o));
				check_true(output_data_o[`SMEM_CL-1:96] == '0 && output_data_o[31:17] == '0,
					"nonzero bits outside the result fields");
				lines_seen++;
			end
		end
	end

	initial begin : watchdog
		int limit;
		int cycles;
		limit = 200 * total_bases() + 1000; // generous per base
		cycles = 0;
		while (cycles < limit) begin
			@(posedge Clk_32UI);
			cycles++;
		end
		$display("timeout: only %0d of %0d result lines after %0d cycles", lines_seen, NUM_READS, cycles);
		$display("Simulation failed");
		$finish;
	end

	initial begin : stimulus
		rst_n_i = 1'b0;
		load_valid_i = 1'b0;
		load_data_i = '0;
		batch_size_i = NUM_READS[`SMEM_READ_NUM_W:0];
		mem_ack_i = 1'b0;
		occ_k_i = '0;
		occ_l_i = '0;
		output_permit_i = 1'b0;
		lfsr_q = 32'h3354d259;
		for (int i = 0; i < NUM_READS; i++)
			model_read(i);
		repeat (16) @(posedge Clk_32UI);
		rst_n_i <= 1'b1;
		@(posedge Clk_32UI);
		check_true(load_ready_o, "load_ready_o low after reset");
		check_true(!(load_done_o || mem_req_o || output_request_o || output_valid_o || output_finish_o),
			"control output high after reset");
		send_word(param_word());
		for (int i = 0; i < NUM_READS; i++)
			send_word(read_word(i));
		load_valid_i <= 1'b0;
		while (lines_seen < NUM_READS)
			@(negedge Clk_32UI);
		repeat (40) @(negedge Clk_32UI); // room for a stray line
		check_true(load_done_o, "load_done_o low at the end of the batch");
		check_true(exp_req.size() == 0, "memory requests missing at the end");
		$display("checks: %0d errors: %0d", checks, errors);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

/* smem_accel.f */
+incdir+rtl
+incdir+bench
rtl/smem_pkg.sv
rtl/smem_fifo.sv
rtl/read_loader.sv
rtl/fm_extend.sv
rtl/result_writer.sv
rtl/smem_top.sv
bench/smem_tb.sv

/* Makefile */
TOP      ?= smem_tb
FILELIST ?= smem_accel.f
VFLAGS   ?= --binary --timing --assert
OBJ_DIR  ?= obj_dir
PASS_MSG := Simulation completed successfully

.PHONY: all lint build sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module $(TOP) -f $(FILELIST)

build:
	verilator $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# status comes from the pass message in the output
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
